//--- common/physics_pkg.sv
package physics_pkg;

	// 16.16 fixed point throughout the integrator
	localparam int FRACTION_BITS = 16;
	localparam logic signed [31:0] ONE_PIXEL = 32'sh0001_0000;	// 1.0, lift on attack start

	localparam logic signed [31:0] JOYSTICK_CENTER = 32'sd128;	// Raw stick rest value
	localparam logic signed [31:0] JUMP_SPEED = 32'sh0003_0000;	// 3 px per tick upward

	// Attack vibration around the anchor, in raw fixed-point units
	localparam logic signed [31:0] VIBRATION_SPAN = 32'sd8;
	localparam logic signed [31:0] VIBRATION_STEP = 32'sd2;

	// Visible area
	localparam int SCREEN_WIDTH = 640;
	localparam int SCREEN_HEIGHT = 480;
	localparam int COLUMN_BITS = 10;
	localparam int ROW_BITS = 9;
	localparam int COLUMN_MAX = SCREEN_WIDTH - 1;
	localparam int ROW_MAX = SCREEN_HEIGHT - 1;

	// Trail FIFO geometry
	localparam int TRAIL_DEPTH = 8;
	localparam int TRAIL_PTR_BITS = $clog2(TRAIL_DEPTH);
	localparam int TRAIL_COUNT_BITS = $clog2(TRAIL_DEPTH + 1);
	localparam logic [TRAIL_COUNT_BITS-1:0] TRAIL_FULL_COUNT = TRAIL_COUNT_BITS'(TRAIL_DEPTH);

	// Collision codes on wall[2:0]
	localparam logic [2:0] WALL_LEFT = 3'b110;
	localparam logic [2:0] WALL_RIGHT = 3'b111;
	localparam logic [2:0] WALL_UP = 3'b101;
	localparam logic [2:0] WALL_DOWN = 3'b100;

	typedef struct packed {
		logic signed [31:0] mass;
		logic signed [31:0] gravity;
		logic signed [31:0] wind;				// Drag divisor
		logic [31:0] start_position;			// X integer high half, Y low half
	} player_config;

	typedef struct packed {
		logic [31:0] controller;				// Bit 20 jump, [15:8] stick X, [7:0] stick Y
		logic [31:0] knockback;					// X high half, Y low half
		logic [3:0] wall;
		logic attack;
		logic freeze;
	} player_inputs;

	typedef struct packed {
		logic signed [31:0] move_x;
		logic signed [31:0] move_y;
		logic signed [31:0] knock_x;
		logic signed [31:0] knock_y;
		logic jump;
		logic drop_through;
		logic on_ground;
		logic hit_left;
		logic hit_right;
		logic hit_up;
	} motion_terms;

	typedef struct packed {
		logic signed [15:0] x;					// Integer parts only
		logic signed [15:0] y;
	} position_sample;

	typedef struct packed {
		logic [COLUMN_BITS-1:0] column;
		logic [ROW_BITS-1:0] row;
		logic on_screen;
	} screen_pixel;

endpackage

//--- physics/player_input_decoder.sv
`timescale 1ns/10ps

module player_input_decoder (
	input physics_pkg::player_inputs inputs,
	output physics_pkg::motion_terms terms
);

	logic [7:0] stick_x;
	logic [7:0] stick_y;
	logic [2:0] wall_code;
	logic platform;

	assign stick_x = inputs.controller[15:8];
	assign stick_y = inputs.controller[7:0];
	assign wall_code = inputs.wall[2:0];

	// Platform needs both upper wall bits
	assign platform = inputs.wall[3] & inputs.wall[2];

	always_comb begin
		// Recenter stick to -128..127, zero-extend first so the subtract is signed
		terms.move_x = $signed({24'd0, stick_x}) - physics_pkg::JOYSTICK_CENTER;
		terms.move_y = $signed({24'd0, stick_y}) - physics_pkg::JOYSTICK_CENTER;

		// Knockback halves, each sign-extended on its own sign bit
		terms.knock_x = {{16{inputs.knockback[31]}}, inputs.knockback[31:16]};
		terms.knock_y = {{16{inputs.knockback[15]}}, inputs.knockback[15:0]};

		terms.jump = inputs.controller[20];
		terms.drop_through = (stick_y[7:4] == 4'd0);		// Stick Y 0..15, pulled down

		// Platform only holds the player while the stick is not pulled through it
		terms.on_ground = (wall_code == physics_pkg::WALL_DOWN)
			| (platform & ~terms.drop_through);

		terms.hit_left = (wall_code == physics_pkg::WALL_LEFT);
		terms.hit_right = (wall_code == physics_pkg::WALL_RIGHT);
		terms.hit_up = (wall_code == physics_pkg::WALL_UP);
	end

endmodule

//--- physics/physics_coprocessor.sv
`timescale 1ns/10ps

module physics_coprocessor (
	input logic clock,
	input logic reset,
	input logic tick,									// One step per pulse
	input physics_pkg::player_config cfg,
	input physics_pkg::player_inputs inputs,
	output physics_pkg::position_sample sample,
	output logic sample_valid
);

	physics_pkg::motion_terms terms;

	// Integrator state, Y grows upward
	logic signed [31:0] pos_x, pos_y;
	logic signed [31:0] vel_x, vel_y;
	logic signed [31:0] accel_x, accel_y;
	logic signed [31:0] anchor;						// pos_y at attack start
	logic attack_history;

	// Derived terms, all from pre-tick values
	logic signed [31:0] steer_x, steer_y;
	logic signed [31:0] drag_x, drag_y;
	logic signed [31:0] air_vel_x, air_vel_y;
	logic signed [31:0] lifted_y;
	logic vibrate_up;
	logic attack_start, attack_hold;

	player_input_decoder decoder (
		.inputs(inputs),
		.terms(terms)
	);

	assign steer_x = terms.move_x / cfg.mass;			// Truncates toward zero
	assign steer_y = terms.move_y / cfg.mass;

	// Cubic drag, wraps at 32 bits
	assign drag_x = vel_x * vel_x * vel_x / cfg.wind;
	assign drag_y = vel_y * vel_y * vel_y / cfg.wind;

	assign air_vel_x = vel_x + accel_x;
	assign air_vel_y = vel_y + accel_y;

	assign lifted_y = pos_y + physics_pkg::ONE_PIXEL;
	assign vibrate_up = (pos_y < anchor + physics_pkg::VIBRATION_SPAN);

	assign attack_start = inputs.attack & ~attack_history;
	assign attack_hold = inputs.attack & attack_history;

	// Integer parts leave as the sample
	assign sample.x = pos_x[31:physics_pkg::FRACTION_BITS];
	assign sample.y = pos_y[31:physics_pkg::FRACTION_BITS];

	always_ff @(posedge clock) begin
		if (reset) begin
			pos_x <= {cfg.start_position[31:16], {physics_pkg::FRACTION_BITS{1'b0}}};
			pos_y <= {cfg.start_position[15:0], {physics_pkg::FRACTION_BITS{1'b0}}};
			vel_x <= '0;
			vel_y <= '0;
			accel_x <= '0;
			accel_y <= '0;
			anchor <= '0;
			attack_history <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= tick;						// Sample follows every step
			if (tick) begin
				attack_history <= inputs.attack;		// Tracked even while frozen
				if (!inputs.freeze) begin
					if (attack_start) begin
						// Lift off the ground and remember where
						pos_y <= lifted_y;
						anchor <= lifted_y;
					end else if (attack_hold) begin
						accel_x <= '0;
						accel_y <= '0;
						vel_x <= terms.knock_x / cfg.mass;
						vel_y <= terms.knock_y / cfg.mass;
						if (vibrate_up)
							pos_y <= pos_y + physics_pkg::VIBRATION_STEP;
						else
							pos_y <= pos_y - physics_pkg::VIBRATION_STEP;
					end else if (terms.on_ground) begin
						accel_x <= '0;
						accel_y <= '0;
						vel_x <= steer_x;
						vel_y <= terms.jump ? physics_pkg::JUMP_SPEED : 32'sd0;
						pos_x <= pos_x + vel_x;			// Y stays on the floor
					end else begin
						accel_x <= steer_x - drag_x;
						accel_y <= steer_y - cfg.gravity - drag_y;
						pos_x <= pos_x + vel_x;
						pos_y <= pos_y + vel_y;
						// Walls stop only motion pointing into them
						if ((terms.hit_left && air_vel_x < 0) || (terms.hit_right && air_vel_x > 0))
							vel_x <= '0;
						else
							vel_x <= air_vel_x;
						if (terms.hit_up && air_vel_y > 0)
							vel_y <= '0;
						else
							vel_y <= air_vel_y;
					end
				end
			end
		end
	end

	// Divisors are configuration, never zero in operation
	assert property (@(posedge clock) disable iff (reset)
		cfg.mass != 0 && cfg.wind != 0)
		else $error("mass or wind is zero");

	// Tick is a pulse, so the sample strobe must be too
	assert property (@(posedge clock) disable iff (reset)
		sample_valid |=> !sample_valid)
		else $error("sample_valid held for two cycles");

endmodule

//--- source/trail_buffer.sv
`timescale 1ns/10ps

module trail_buffer (
	input logic clock,
	input logic reset,
	input logic push,
	input physics_pkg::position_sample push_data,
	input logic pop,
	output physics_pkg::position_sample head,
	output logic empty,
	output logic overflow								// Sticky until reset
);

	physics_pkg::position_sample entries [physics_pkg::TRAIL_DEPTH];

	logic [physics_pkg::TRAIL_PTR_BITS-1:0] rd_ptr, wr_ptr;
	logic [physics_pkg::TRAIL_COUNT_BITS-1:0] count;
	logic full;
	logic write_en, read_en;

	assign full = (count == physics_pkg::TRAIL_FULL_COUNT);
	assign empty = (count == '0);

	// A push into a full buffer is lost, even alongside a pop
	assign write_en = push & ~full;
	assign read_en = pop & ~empty;

	assign head = entries[rd_ptr];

	always_ff @(posedge clock) begin
		if (write_en)
			entries[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			// Depth is a power of two, pointers wrap on their own
			if (write_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (read_en)
				rd_ptr <= rd_ptr + 1'b1;

			case ({write_en, read_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;		// Idle or both
			endcase

			if (push && full)
				overflow <= 1'b1;
		end
	end

	// Reader must only pop what is there
	assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty)
		else $error("pop while trail buffer empty");

endmodule

//--- source/screen_clipper.sv
`timescale 1ns/10ps

module screen_clipper (
	input logic clock,
	input logic reset,
	input physics_pkg::position_sample head,
	input logic empty,
	input logic display_busy,
	output logic pop,
	output physics_pkg::screen_pixel pixel,
	output logic pixel_valid
);

	// Sign-extended head coordinates
	int head_x, head_y;
	int column_clamped, row_clamped, row_flipped;
	logic x_clipped, y_clipped;
	physics_pkg::screen_pixel pixel_next;

	// Take one sample per free display cycle
	assign pop = ~empty & ~display_busy;

	assign head_x = int'(head.x);
	assign head_y = int'(head.y);

	always_comb begin
		x_clipped = 1'b1;
		y_clipped = 1'b1;
		if (head_x < 0)
			column_clamped = 0;
		else if (head_x > physics_pkg::COLUMN_MAX)
			column_clamped = physics_pkg::COLUMN_MAX;
		else begin
			column_clamped = head_x;
			x_clipped = 1'b0;
		end

		if (head_y < 0)
			row_clamped = 0;
		else if (head_y > physics_pkg::ROW_MAX)
			row_clamped = physics_pkg::ROW_MAX;
		else begin
			row_clamped = head_y;
			y_clipped = 1'b0;
		end

		row_flipped = physics_pkg::ROW_MAX - row_clamped;		// Display rows count down

		pixel_next.column = column_clamped[physics_pkg::COLUMN_BITS-1:0];
		pixel_next.row = row_flipped[physics_pkg::ROW_BITS-1:0];
		pixel_next.on_screen = ~x_clipped & ~y_clipped;
	end

	always_ff @(posedge clock) begin
		if (pop)
			pixel <= pixel_next;			// Payload only
	end

	always_ff @(posedge clock) begin
		if (reset)
			pixel_valid <= 1'b0;
		else
			pixel_valid <= pop;				// One cycle behind pop
	end

endmodule

//--- source/player_physics_top.sv
`timescale 1ns/10ps

module player_physics_top (
	input logic clock,
	input logic reset,
	input logic tick,
	input physics_pkg::player_config cfg,
	input physics_pkg::player_inputs inputs,
	input logic display_busy,
	output physics_pkg::screen_pixel pixel,
	output logic pixel_valid,
	output logic overflow
);

	// Coprocessor to trail
	physics_pkg::position_sample sample;
	logic sample_valid;

	// Trail to clipper
	physics_pkg::position_sample head;
	logic empty;
	logic pop;

	physics_coprocessor coprocessor (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.cfg(cfg),
		.inputs(inputs),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	trail_buffer trail (
		.clock(clock),
		.reset(reset),
		.push(sample_valid),		// No ready, full drops
		.push_data(sample),
		.pop(pop),
		.head(head),
		.empty(empty),
		.overflow(overflow)
	);

	screen_clipper clipper (
		.clock(clock),
		.reset(reset),
		.head(head),
		.empty(empty),
		.display_busy(display_busy),
		.pop(pop),
		.pixel(pixel),
		.pixel_valid(pixel_valid)
	);

endmodule

//--- dv/physics_ref.svh
`ifndef PHYSICS_REF_SVH
`define PHYSICS_REF_SVH

// Model state, 16.16 like the integrator
typedef struct packed {
	int pos_x;
	int pos_y;
	int vel_x;
	int vel_y;
	int accel_x;
	int accel_y;
	int anchor;			// pos_y when the attack began
	logic history;		// Attack input of the previous tick
} ref_state;

// One tick of player motion, straight from the step rules
function automatic ref_state physics_step(input ref_state s,
	input physics_pkg::player_config c, input physics_pkg::player_inputs ins);
	ref_state n;
	int move_x, move_y, knock_x, knock_y;
	int air_x, air_y;
	logic [2:0] code;
	logic drop, ground;
	n = s;
	n.history = ins.attack;		// Kept up to date even when frozen
	if (ins.freeze)
		return n;
	code = ins.wall[2:0];
	move_x = int'(ins.controller[15:8]) - physics_pkg::JOYSTICK_CENTER;
	move_y = int'(ins.controller[7:0]) - physics_pkg::JOYSTICK_CENTER;
	knock_x = int'($signed(ins.knockback[31:16]));	// High half is X
	knock_y = int'($signed(ins.knockback[15:0]));
	drop = (ins.controller[7:0] <= 8'd15);
	ground = (code == physics_pkg::WALL_DOWN) || (ins.wall[3] && ins.wall[2] && !drop);
	if (ins.attack && !s.history) begin
		n.pos_y = s.pos_y + physics_pkg::ONE_PIXEL;
		n.anchor = n.pos_y;
	end else if (ins.attack) begin
		n.accel_x = 0;
		n.accel_y = 0;
		n.vel_x = knock_x / c.mass;
		n.vel_y = knock_y / c.mass;
		if (s.pos_y < s.anchor + physics_pkg::VIBRATION_SPAN)
			n.pos_y = s.pos_y + physics_pkg::VIBRATION_STEP;
		else
			n.pos_y = s.pos_y - physics_pkg::VIBRATION_STEP;
	end else if (ground) begin
		n.accel_x = 0;
		n.accel_y = 0;
		n.vel_x = move_x / c.mass;
		n.vel_y = ins.controller[20] ? physics_pkg::JUMP_SPEED : 0;
		n.pos_x = s.pos_x + s.vel_x;
	end else begin
		n.accel_x = move_x / c.mass - (s.vel_x * s.vel_x * s.vel_x) / c.wind;
		n.accel_y = move_y / c.mass - c.gravity - (s.vel_y * s.vel_y * s.vel_y) / c.wind;
		n.pos_x = s.pos_x + s.vel_x;
		n.pos_y = s.pos_y + s.vel_y;
		air_x = s.vel_x + s.accel_x;
		air_y = s.vel_y + s.accel_y;
		n.vel_x = air_x;
		n.vel_y = air_y;
		if ((code == physics_pkg::WALL_LEFT && air_x < 0) ||
			(code == physics_pkg::WALL_RIGHT && air_x > 0))
			n.vel_x = 0;
		if (code == physics_pkg::WALL_UP && air_y > 0)
			n.vel_y = 0;
	end
	return n;
endfunction

// Screen pixel of a model position, Y flipped
function automatic physics_pkg::screen_pixel to_pixel(input ref_state s);
	physics_pkg::screen_pixel p;
	int x, y;
	x = s.pos_x >>> physics_pkg::FRACTION_BITS;	// Integer part, sign kept
	y = s.pos_y >>> physics_pkg::FRACTION_BITS;
	p.on_screen = 1'b1;
	if (x < 0 || x > physics_pkg::SCREEN_WIDTH - 1) begin
		x = (x < 0) ? 0 : physics_pkg::SCREEN_WIDTH - 1;
		p.on_screen = 1'b0;
	end
	if (y < 0 || y > physics_pkg::SCREEN_HEIGHT - 1) begin
		y = (y < 0) ? 0 : physics_pkg::SCREEN_HEIGHT - 1;
		p.on_screen = 1'b0;
	end
	y = physics_pkg::SCREEN_HEIGHT - 1 - y;
	p.column = x[physics_pkg::COLUMN_BITS-1:0];
	p.row = y[physics_pkg::ROW_BITS-1:0];
	return p;
endfunction

`endif

//--- dv/physics_tb.sv
`timescale 1ns/10ps

module physics_tb;

	`include "physics_ref.svh"

	logic clock;
	logic reset;
	logic tick;
	physics_pkg::player_config cfg;
	physics_pkg::player_inputs inputs;
	logic display_busy;
	physics_pkg::screen_pixel pixel;
	logic pixel_valid;
	logic overflow;

	ref_state model;
	physics_pkg::screen_pixel expected [$];	// Pixels still inside the DUT
	int seed;
	string test_name;

	player_physics_top dut (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.cfg(cfg),
		.inputs(inputs),
		.display_busy(display_busy),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.overflow(overflow)
	);

	always #50 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] expected_value,
		input logic [31:0] actual_value);
		if (expected_value !== actual_value) begin
			$display("Fail %s: expected %h, actual %h", name, expected_value, actual_value);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [7:0] random_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	function automatic physics_pkg::player_inputs make_inputs(input logic [7:0] stick_x,
		input logic [7:0] stick_y, input logic jump, input logic [3:0] wall,
		input logic attack, input logic freeze, input logic [31:0] knockback);
		physics_pkg::player_inputs p;
		p.controller = {11'd0, jump, 4'd0, stick_x, stick_y};	// Jump on bit 20
		p.knockback = knockback;
		p.wall = wall;
		p.attack = attack;
		p.freeze = freeze;
		return p;
	endfunction

	// New start position only takes effect through reset
	task automatic restart(input logic [15:0] start_x, input logic [15:0] start_y);
		@(posedge clock);
		#1;
		cfg.start_position = {start_x, start_y};
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		model = '0;
		model.pos_x = {start_x, 16'h0000};
		model.pos_y = {start_y, 16'h0000};
	endtask

	// One tick pulse plus the model step
	task automatic step(input physics_pkg::player_inputs next_inputs);
		@(posedge clock);
		#1;
		inputs = next_inputs;
		tick = 1'b1;
		model = physics_step(model, cfg, next_inputs);
		if (expected.size() < physics_pkg::TRAIL_DEPTH)
			expected.push_back(to_pixel(model));		// Else the full buffer drops it
		@(posedge clock);
		#1;
		tick = 1'b0;
	endtask

	task automatic set_busy(input logic level);
		@(posedge clock);
		#1;
		display_busy = level;
	endtask

	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while (expected.size() != 0 && cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		if (expected.size() != 0) begin
			$display("Timeout in %s: %0d pixels never came out", test_name, expected.size());
			$display("Simulation failed");
			$fatal(1, "drain timeout");
		end
	endtask

	// Floor steps set a tiny velocity and the air steps then press into the wall
	task automatic push_then_hit(input logic [7:0] first_x, input logic [7:0] second_x,
		input logic [7:0] press_x, input logic [3:0] wall);
		step(make_inputs(first_x, 8'h80, 1'b0, {1'b0, physics_pkg::WALL_DOWN},
			1'b0, 1'b0, 32'd0));
		step(make_inputs(second_x, 8'h80, 1'b0, {1'b0, physics_pkg::WALL_DOWN},
			1'b0, 1'b0, 32'd0));
		repeat (3) step(make_inputs(press_x, 8'h80, 1'b0, wall, 1'b0, 1'b0, 32'd0));
		wait_drained(50);
	endtask

	task automatic clip_case(input logic [15:0] start_x, input logic [15:0] start_y);
		restart(start_x, start_y);
		repeat (2) step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b0, 1'b0, 32'd0));
		wait_drained(50);
	endtask

	always @(negedge clock) begin : compare_pixels
		physics_pkg::screen_pixel want;
		if (!reset && pixel_valid) begin
			if (expected.size() == 0) begin
				$display("A pixel came out in %s while none was expected", test_name);
				$display("Simulation failed");
				$fatal(1, "unexpected pixel");
			end else begin
				want = expected.pop_front();
				check_value(test_name, 32'(want), 32'(pixel));
			end
		end
	end

	initial begin
		logic [7:0] stick_y;
		logic [3:0] wall;
		seed = 32'hbddb6928;
		clock = 1'b0;
		reset = 1'b1;
		tick = 1'b0;
		display_busy = 1'b0;
		inputs = '0;
		cfg.mass = 32'sd4;
		cfg.gravity = 32'sh0000_2000;		// 1/8 px per tick squared
		cfg.wind = 32'sh0001_0000;
		cfg.start_position = '0;

		test_name = "free_fall";
		restart(16'd320, 16'd240);
		for (int i = 0; i < 12; i++)
			step(make_inputs(random_byte(), random_byte(), 1'b0, 4'd0, 1'b0, 1'b0, 32'd0));
		wait_drained(50);

		test_name = "ground";
		restart(16'd100, 16'd50);
		for (int i = 0; i < 12; i++) begin
			stick_y = random_byte();
			if (i % 2 == 1)
				stick_y = stick_y & 8'h0F;		// Pulled through a platform
			// Floor, then platforms that also carry a side code
			wall = (i % 3 == 0) ? {1'b0, physics_pkg::WALL_DOWN} : (i % 3 == 1) ? 4'b1110 : 4'b1101;
			step(make_inputs(random_byte(), stick_y, i % 3 == 0, wall, 1'b0, 1'b0, 32'd0));
		end
		repeat (3) step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b0, 1'b0, 32'd0));
		wait_drained(50);

		test_name = "wall_clamp";
		restart(16'd320, 16'd240);
		push_then_hit(8'h80, 8'h80, 8'h00, {1'b0, physics_pkg::WALL_LEFT});	// On a whole pixel
		push_then_hit(8'h00, 8'hFF, 8'hFF, {1'b0, physics_pkg::WALL_RIGHT});	// Just below one
		// Jump gives upward speed for the ceiling
		step(make_inputs(8'h80, 8'h80, 1'b1, {1'b0, physics_pkg::WALL_DOWN}, 1'b0, 1'b0, 32'd0));
		repeat (3) step(make_inputs(8'h80, 8'hFF, 1'b0, {1'b0, physics_pkg::WALL_UP},
			1'b0, 1'b0, 32'd0));
		wait_drained(50);

		test_name = "attack_freeze";
		restart(16'd200, 16'd200);		// Anchor lands on a whole pixel
		step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b1, 1'b0, 32'd0));	// Lift
		repeat (5) step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b1, 1'b0, random_word()));
		// Knock X backward and Y upward
		step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b1, 1'b0, 32'h8000_4000));
		repeat (2) step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b1, 1'b1, 32'd0));
		repeat (2) step(make_inputs(8'h80, 8'h80, 1'b0, 4'd0, 1'b0, 1'b1, 32'd0));
		repeat (2) step(make_inputs(random_byte(), 8'h80, 1'b0, 4'd0, 1'b0, 1'b0, 32'd0));
		wait_drained(50);

		test_name = "clipping";
		clip_case(16'hFFEC, 16'd100);		// x = -20
		clip_case(16'd700, 16'd500);
		clip_case(16'd100, 16'hFFFB);		// y = -5
		clip_case(16'd639, 16'd479);		// Last visible corner

		test_name = "back_pressure";
		check_value("back_pressure overflow idle", 32'd0, {31'd0, overflow});
		set_busy(1'b1);
		repeat (10) step(make_inputs(random_byte(), random_byte(), 1'b0, 4'd0, 1'b0, 1'b0,
			32'd0));
		repeat (2) @(posedge clock);		// Last push lands one cycle after sample_valid
		check_value("back_pressure overflow set", 32'd1, {31'd0, overflow});
		set_busy(1'b0);
		wait_drained(50);
		check_value("back_pressure overflow sticky", 32'd1, {31'd0, overflow});

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- src.f
+incdir+dv
common/physics_pkg.sv
physics/player_input_decoder.sv
physics/physics_coprocessor.sv
source/trail_buffer.sv
source/screen_clipper.sv
source/player_physics_top.sv
dv/physics_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the player physics testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module physics_tb \
	-f src.f -o physics_sim > "$LOG" 2>&1 \
	&& ./obj_dir/physics_sim >> "$LOG" 2>&1 \
	|| echo "Build or simulation exited with an error" >> "$LOG"

cat "$LOG"
grep -q "Simulation failed" "$LOG" && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation passed" "$LOG" || { echo "RESULT: FAIL, no pass message"; exit 1; }
echo "RESULT: PASS"
exit 0
